/* hw/mipsPkg.sv */
// --------------------------------------------------
// Shared types for the two-stage MIPS32 integer core
// Only ADD SUB AND OR SLT and ADDI are decoded
// --------------------------------------------------
package mipsPkg;

   // Widths and sizes
   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 5;
   localparam int numRegs      = 32;
   localparam int immWidth     = 16;

   // Primary opcodes
   localparam logic [5:0] opRType = 6'h00;
   localparam logic [5:0] opAddi  = 6'h08;

   // Funct codes for R-type
   localparam logic [5:0] fnAdd = 6'h20;
   localparam logic [5:0] fnSub = 6'h22;
   localparam logic [5:0] fnAnd = 6'h24;
   localparam logic [5:0] fnOr  = 6'h25;
   localparam logic [5:0] fnSlt = 6'h2a;

   typedef enum logic [2:0] {
      aluAdd = 3'd0,
      aluSub = 3'd1,
      aluAnd = 3'd2,
      aluOr  = 3'd3,
      aluSlt = 3'd4
   } aluOpT;

   // R-type field layout
   typedef struct packed {
      logic [5:0]              opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [4:0]              shamt;
      logic [5:0]              funct;
   } rTypeT;

   // I-type field layout
   typedef struct packed {
      logic [5:0]              opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [immWidth-1:0]     imm;
   } iTypeT;

   // Same word seen as R-type or I-type
   typedef union packed {
      rTypeT r;
      iTypeT i;
   } instrWordT;

   // Decoder output, latched by the execute stage
   typedef struct packed {
      logic                    valid;
      aluOpT                   aluOp;
      logic                    useImm;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] dest;
      logic                    writes;
      logic [immWidth-1:0]     imm;
   } decodedT;

   // Writeback bus, also the register file write port
   typedef struct packed {
      logic                    valid;
      logic [regAddrWidth-1:0] regAddr;
      logic [dataWidth-1:0]    data;
   } wbT;

endpackage

/* hw/instrDecode.sv */
// --------------------------------------------------
// Purely combinational decode, no state
// Unknown opcode or funct gives valid low, a bubble
// --------------------------------------------------
`timescale 1ns/1ps

module instrDecode (
   input  logic               instrValid,
   input  mipsPkg::instrWordT instr,
   output mipsPkg::decodedT   dec
);
   import mipsPkg::*;

   logic known;

   always_comb begin
      // Defaults for a bubble
      dec   = '0;
      known = 1'b0;

      // Source fields sit at the same bits in both views
      dec.rs  = instr.r.rs;
      dec.rt  = instr.r.rt;
      dec.imm = instr.i.imm;

      case (instr.r.opcode)
         opRType: begin
            dec.useImm = 1'b0;
            dec.dest   = instr.r.rd;
            known      = 1'b1;
            // ALU op comes from funct
            case (instr.r.funct)
               fnAdd: dec.aluOp = aluAdd;
               fnSub: dec.aluOp = aluSub;
               fnAnd: dec.aluOp = aluAnd;
               fnOr: dec.aluOp = aluOr;
               fnSlt: dec.aluOp = aluSlt;
               default: begin
                  dec.aluOp = aluAdd;
                  known     = 1'b0;
               end
            endcase
         end
         opAddi: begin
            // Immediate form writes rt
            dec.aluOp  = aluAdd;
            dec.useImm = 1'b1;
            dec.dest   = instr.i.rt;
            known      = 1'b1;
         end
         default: begin
            known = 1'b0;
         end
      endcase

      dec.valid = instrValid && known;
      // Register zero never written
      dec.writes = dec.valid && (dec.dest != '0);
   end

endmodule

/* hw/regFile.sv */
// --------------------------------------------------
// 32 x 32 register file, asynchronous reads
// Register zero reads zero, same-cycle write bypass
// --------------------------------------------------
`timescale 1ns/1ps

module regFile (
   input  logic                                Clk,
   input  logic                                reset,
   input  logic [mipsPkg::regAddrWidth-1:0]    rdAddrA,
   input  logic [mipsPkg::regAddrWidth-1:0]    rdAddrB,
   output logic [mipsPkg::dataWidth-1:0]       rdDataA,
   output logic [mipsPkg::dataWidth-1:0]       rdDataB,
   input  mipsPkg::wbT                         wb
);
   import mipsPkg::*;

   logic [dataWidth-1:0] regs [numRegs];

   // One read port, bypass from the write port first
   function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
      logic [dataWidth-1:0] value;
      if (addr == '0) begin
         value = '0;
      end else if (wb.valid && (wb.regAddr == addr)) begin
         value = wb.data;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   // Write at the edge ending the wb cycle
   always_ff @(posedge Clk) begin
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid && (wb.regAddr != '0)) begin
         regs[wb.regAddr] <= wb.data;
      end
   end

   // Both read ports
   always_comb begin
      rdDataA = readPort(rdAddrA);
      rdDataB = readPort(rdAddrB);
   end

endmodule

/* hw/execStage.sv */
// --------------------------------------------------
// Execute register, forwarding, ALU and wb register
// Two edges from dec/opA/opB to wb, no stall path
// --------------------------------------------------
`timescale 1ns/1ps

module execStage (
   input  logic                          Clk,
   input  logic                          reset,
   input  mipsPkg::decodedT              dec,
   input  logic [mipsPkg::dataWidth-1:0] opA,
   input  logic [mipsPkg::dataWidth-1:0] opB,
   output mipsPkg::wbT                   wb
);
   import mipsPkg::*;

   // Execute register contents
   decodedT              exDec;
   logic [dataWidth-1:0] exOpA;
   logic [dataWidth-1:0] exOpB;

   // Operand selection
   logic                 fwdA;
   logic                 fwdB;
   logic [dataWidth-1:0] srcA;
   logic [dataWidth-1:0] srcB;
   logic [dataWidth-1:0] immExt;
   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluResult;

   // Execute register, valid cleared on reset
   always_ff @(posedge Clk) begin
      if (reset) begin
         exDec.valid <= 1'b0;
      end else begin
         exDec <= dec;
      end
   end

   // Operand payload
   always_ff @(posedge Clk) begin
      exOpA <= opA;
      exOpB <= opB;
   end

   // Distance-1 hazard
   // wb holds the previous instruction, not yet in the register file
   always_comb begin
      fwdA = wb.valid && (wb.regAddr != '0) && (wb.regAddr == exDec.rs);
      fwdB = wb.valid && (wb.regAddr != '0) && (wb.regAddr == exDec.rt);
      srcA = fwdA ? wb.data : exOpA;
      srcB = fwdB ? wb.data : exOpB;
   end

   // Sign-extended immediate for ADDI
   assign immExt = {{(dataWidth - immWidth){exDec.imm[immWidth-1]}}, exDec.imm};
   assign aluB   = exDec.useImm ? immExt : srcB;

   // ALU
   always_comb begin
      case (exDec.aluOp)
         aluAdd: aluResult = srcA + aluB;
         aluSub: aluResult = srcA - aluB;
         aluAnd: aluResult = srcA & aluB;
         aluOr: aluResult = srcA | aluB;
         // Signed compare
         aluSlt: aluResult = ($signed(srcA) < $signed(aluB)) ? 32'd1 : 32'd0;
         default: aluResult = srcA + aluB;
      endcase
   end

   // Writeback register
   // Valid only for a known instruction with a nonzero dest
   always_ff @(posedge Clk) begin
      if (reset) begin
         wb.valid <= 1'b0;
      end else begin
         wb.valid   <= exDec.valid && exDec.writes;
         wb.regAddr <= exDec.dest;
         wb.data    <= aluResult;
      end
   end

endmodule

/* hw/mipsCore.sv */
// --------------------------------------------------
// Core top, instruction in on a one-cycle strobe
// wb.valid follows instrValid by exactly two edges
// --------------------------------------------------
`timescale 1ns/1ps

module mipsCore (
   input  logic               Clk,
   input  logic               reset,
   input  logic               instrValid,
   input  mipsPkg::instrWordT instr,
   output mipsPkg::wbT        wb
);
   import mipsPkg::*;

   // Decode and read side by side
   decodedT              dec;
   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;

   // Decoder
   instrDecode i_instrDecode (
      .instrValid (instrValid),
      .instr      (instr),
      .dec        (dec)
   );

   // Register file, read addresses straight from the word
   regFile i_regFile (
      .Clk     (Clk),
      .reset   (reset),
      .rdAddrA (instr.r.rs),
      .rdAddrB (instr.r.rt),
      .rdDataA (opA),
      .rdDataB (opB),
      .wb      (wb)
   );

   // Execute and writeback
   execStage i_execStage (
      .Clk   (Clk),
      .reset (reset),
      .dec   (dec),
      .opA   (opA),
      .opB   (opB),
      .wb    (wb)
   );

endmodule

/* sim/clockGen.sv */
// --------------------------------------------------
// 4 ns clock, reset high for the first 3 rising edges
// --------------------------------------------------
`timescale 1ns/1ps

module clockGen (
   output logic Clk,
   output logic reset
);
   localparam int halfPeriod  = 2;
   localparam int resetCycles = 3;

   // Free-running clock
   initial begin
      Clk = 1'b0;
      forever #halfPeriod Clk = ~Clk;
   end

   // Synchronous release on a rising edge
   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge Clk);
      reset <= 1'b0;
   end

endmodule

/* sim/mipsCore_props.sv */
// --------------------------------------------------
// Timing and sanity properties on the core's wb bus
// Assumes wb.valid follows instrValid by two edges
// --------------------------------------------------
`timescale 1ns/1ps

module mipsCoreProps (
   input logic        Clk,
   input logic        reset,
   input logic        instrValid,
   input mipsPkg::wbT wb
);
   import mipsPkg::*;

   // Every writeback traces back to an issue two edges earlier
   wbFromIssue: assert property (
      @(posedge Clk) disable iff (reset)
      wb.valid |-> $past(instrValid, 2)
   ) else begin
      $error("wb.valid without instrValid two cycles before");
   end

   // Register zero is never a writeback target
   wbNotZero: assert property (
      @(posedge Clk) disable iff (reset)
      wb.valid |-> (wb.regAddr != '0)
   ) else begin
      $error("wb.valid with wb.regAddr of zero");
   end

   // Reset clears the writeback register
   wbLowAfterReset: assert property (
      @(posedge Clk)
      reset |=> !wb.valid
   ) else begin
      $error("wb.valid high in the cycle after reset");
   end

endmodule

/* sim/tbMips.sv */
// --------------------------------------------------
// Random self-checking testbench for mipsCore
// Fixed seed and a model that runs each instruction at issue
// --------------------------------------------------
`timescale 1ns/1ps

module tbMips;
   import mipsPkg::*;

   localparam int unsigned seedValue    = 32'h7d0d_5b67;
   localparam int          numInstr     = 2000;
   localparam int          resetTimeout = 20;
   localparam int          drainTimeout = 10;

   // Expected writeback and the negedge count it is due at
   typedef struct packed {
      logic [31:0] due;
      wbT          wb;
   } expectT;

   logic      Clk;
   logic      reset;
   logic      instrValid;
   instrWordT instr;
   wbT        wb;

   // Reference model state
   logic [dataWidth-1:0]    modelRegs [numRegs];
   logic [regAddrWidth-1:0] recentDest [3];
   expectT                  expQ [$];
   logic [31:0]             cycle = 32'd0;

   clockGen i_clockGen (
      .Clk   (Clk),
      .reset (reset)
   );

   mipsCore i_dut (
      .Clk        (Clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .wb         (wb)
   );

   bind mipsCore mipsCoreProps i_props (
      .Clk        (Clk),
      .reset      (reset),
      .instrValid (instrValid),
      .wb         (wb)
   );

   task automatic reportError(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic wrongValue(input string name, input logic [31:0] expVal,
                             input logic [31:0] gotVal);
      reportError($sformatf("FAILED at %0t: %s expected %h got %h",
                            $time, name, expVal, gotVal));
   endtask

   // Compares each field of a writeback
   task automatic checkWb(input wbT expected, input wbT actual);
      if (actual.valid !== expected.valid) begin
         wrongValue("wb.valid", 32'(expected.valid), 32'(actual.valid));
      end
      if (actual.regAddr !== expected.regAddr) begin
         wrongValue("wb.regAddr", 32'(expected.regAddr), 32'(actual.regAddr));
      end
      if (actual.data !== expected.data) begin
         wrongValue("wb.data", expected.data, actual.data);
      end
   endtask

   task automatic checkReg(input logic [regAddrWidth-1:0] addr);
      logic [dataWidth-1:0] got;
      got = i_dut.i_regFile.regs[addr];
      if (got !== modelRegs[addr]) begin
         wrongValue($sformatf("regs[%0d]", addr), modelRegs[addr], got);
      end
   endtask

   // Sources lean toward the last destinations for hazards
   function automatic logic [regAddrWidth-1:0] pickSource();
      if ($urandom_range(0, 99) < 60) begin
         return recentDest[$urandom_range(0, 2)];
      end
      return regAddrWidth'($urandom_range(0, numRegs - 1));
   endfunction

   // Occasional write to register zero
   function automatic logic [regAddrWidth-1:0] pickDest();
      if ($urandom_range(0, 19) == 0) begin
         return '0;
      end
      return regAddrWidth'($urandom_range(1, numRegs - 1));
   endfunction

   function automatic instrWordT buildInstr();
      instrWordT   w;
      int unsigned kind;
      logic [5:0]  code;
      kind   = $urandom_range(0, 99);
      w      = '0;
      w.r.rs = pickSource();
      w.r.rt = pickSource();
      if (kind < 40) begin
         // ADDI with about half the immediates negative
         w.i.opcode = opAddi;
         w.i.rt     = pickDest();
         w.i.imm    = immWidth'($urandom);
      end else if (kind < 92) begin
         w.r.opcode = opRType;
         w.r.rd     = pickDest();
         case ($urandom_range(0, 4))
            0: w.r.funct = fnAdd;
            1: w.r.funct = fnSub;
            2: w.r.funct = fnAnd;
            3: w.r.funct = fnOr;
            default: w.r.funct = fnSlt;
         endcase
      end else if (kind < 96) begin
         // R-type with a funct outside the subset
         w.r.opcode = opRType;
         w.r.rd     = pickDest();
         do begin
            code = 6'($urandom);
         end while (code inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt});
         w.r.funct = code;
      end else begin
         // Unknown primary opcode
         do begin
            code = 6'($urandom);
         end while (code == opRType || code == opAddi);
         w.r.opcode = code;
         w.r.rd     = pickDest();
      end
      return w;
   endfunction

   // Executes in issue order and queues any writeback
   task automatic runModel(input instrWordT w, input logic [31:0] due);
      logic [dataWidth-1:0]    a;
      logic [dataWidth-1:0]    b;
      logic [dataWidth-1:0]    result;
      logic [regAddrWidth-1:0] dest;
      logic                    known;
      int                      immVal;
      int                      signedA;
      int                      signedB;
      expectT                  e;
      a       = modelRegs[w.r.rs];
      b       = modelRegs[w.r.rt];
      signedA = a;
      signedB = b;
      // Two's complement value of the 16-bit immediate
      immVal  = int'(w.i.imm);
      if (w.i.imm[immWidth-1]) begin
         immVal = immVal - (1 << immWidth);
      end
      result = '0;
      dest   = w.r.rd;
      known  = 1'b1;
      if (w.r.opcode == opAddi) begin
         dest   = w.i.rt;
         result = a + immVal;
      end else if (w.r.opcode == opRType) begin
         case (w.r.funct)
            fnAdd: result = a + b;
            fnSub: result = a - b;
            fnAnd: result = a & b;
            fnOr: result = a | b;
            // Signed compare on plain ints
            fnSlt: result = (signedA < signedB) ? 32'd1 : 32'd0;
            default: known = 1'b0;
         endcase
      end else begin
         known = 1'b0;
      end
      if (known && (dest != '0)) begin
         modelRegs[dest] = result;
         e.due           = due;
         e.wb.valid      = 1'b1;
         e.wb.regAddr    = dest;
         e.wb.data       = result;
         expQ.push_back(e);
         recentDest[2] = recentDest[1];
         recentDest[1] = recentDest[0];
         recentDest[0] = dest;
      end
   endtask

   // Word seen at the next three negedges with wb due on the third
   task automatic issueOne();
      instrWordT w;
      w = buildInstr();
      @(posedge Clk);
      instrValid <= 1'b1;
      instr      <= w;
      runModel(w, cycle + 32'd3);
   endtask

   // Garbage word with the strobe low must do nothing
   task automatic idleCycle();
      @(posedge Clk);
      instrValid <= 1'b0;
      instr      <= instrWordT'($urandom);
   endtask

   task automatic waitResetDone();
      int n;
      n = 0;
      while (reset && n < resetTimeout) begin
         @(posedge Clk);
         n++;
      end
      if (reset) begin
         reportError("Reset was never released");
      end
   endtask

   task automatic waitDrain();
      int n;
      n = 0;
      while (expQ.size() > 0 && n < drainTimeout) begin
         @(posedge Clk);
         n++;
      end
      if (expQ.size() > 0) begin
         reportError("Writebacks still pending after the drain timeout");
      end
   endtask

   // Exact-cycle match against the head of the queue
   task automatic checkCycle();
      if (wb.valid) begin
         if (expQ.size() == 0) begin
            reportError($sformatf("Unexpected writeback to r%0d at %0t", wb.regAddr, $time));
         end else if (expQ[0].due != cycle) begin
            reportError($sformatf("Writeback to r%0d came in cycle %0d but was due in %0d",
                                  wb.regAddr, cycle, expQ[0].due));
         end else begin
            checkWb(expQ[0].wb, wb);
            expQ.delete(0);
         end
      end else if (expQ.size() > 0 && expQ[0].due == cycle) begin
         reportError($sformatf("Missing writeback to r%0d due in cycle %0d",
                               expQ[0].wb.regAddr, cycle));
      end
   endtask

   // Outputs sampled at the falling edge
   always @(negedge Clk) begin
      cycle = cycle + 32'd1;
      if (!reset) begin
         checkCycle();
      end
   end

   initial begin
      instrValid = 1'b0;
      instr      = '0;
      for (int r = 0; r < numRegs; r++) begin
         modelRegs[r] = '0;
      end
      recentDest[0] = 5'd1;
      recentDest[1] = 5'd2;
      recentDest[2] = 5'd3;
      void'($urandom(seedValue));

      waitResetDone();
      // Quiet period with no writeback allowed yet
      repeat ($urandom_range(2, 5)) idleCycle();

      for (int i = 0; i < numInstr; i++) begin
         issueOne();
         if ($urandom_range(0, 99) < 25) begin
            repeat ($urandom_range(1, 3)) idleCycle();
         end
      end
      idleCycle();
      waitDrain();

      // Let the last write reach the register file
      @(posedge Clk);
      @(negedge Clk);
      for (int r = 0; r < numRegs; r++) begin
         checkReg(regAddrWidth'(r));
      end

      if (expQ.size() == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         reportError("Expected writebacks left over at the end of the run");
      end
   end

endmodule

/* verilog.f */
hw/mipsPkg.sv
hw/instrDecode.sv
hw/regFile.sv
hw/execStage.sv
hw/mipsCore.sv
sim/clockGen.sv
sim/mipsCore_props.sv
sim/tbMips.sv

/* run.sh */
#!/bin/sh
# Build and run the mipsCore testbench with Verilator
# Exit status is nonzero unless the log shows the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_TEXT="All tests passed!"

verilator --binary --timing --assert -j 0 \
   --top-module tbMips -f verilog.f --Mdir obj_dir -o simTb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF "$PASS_TEXT" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
